//--- Bender.yml
package:
  name: modexp

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - verilog/montgomery_pkg.sv
      - verilog/modexp_ctrl_pkg.sv
      - verilog/modexp_ifs.sv
      - verilog/operand_store.sv
      - verilog/monpro_engine.sv
      - verilog/exp_sequencer.sv
      - verilog/modexp_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - verification/modexp_assertions.sv
      - verification/modexp_tb.sv

//--- filelist.f
+incdir+include
verilog/montgomery_pkg.sv
verilog/modexp_ctrl_pkg.sv
verilog/modexp_ifs.sv
verilog/operand_store.sv
verilog/monpro_engine.sv
verilog/exp_sequencer.sv
verilog/modexp_top.sv
verification/modexp_assertions.sv
verification/modexp_tb.sv

//--- include/modexp_defines.svh
//************************************************************
// operand sizes, the word width must be a power of two
//************************************************************
`ifndef MODEXP_DEFINES_SVH
`define MODEXP_DEFINES_SVH

`define MODEXP_WORD_WIDTH 16	// bits per word
`define MODEXP_NUM_WORDS 4	// words per operand, 64-bit modulus

`endif

//--- verification/modexp_assertions.sv
//************************************************************
// protocol checks on the top level, bound into modexp_top
//************************************************************
module modexp_assertions (
	input logic clk,
	input logic reset,
	input logic done,
	input logic res_valid,
	input logic mp_start,
	input logic mp_done
);
	import montgomery_pkg::*;

	logic engine_busy;	// between a start and its done
	int valid_len;	// cycles res_valid has been high so far

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			engine_busy <= 1'b0;
			valid_len <= 0;
		end else begin
			if (mp_start)
				engine_busy <= 1'b1;
			else if (mp_done)
				engine_busy <= 1'b0;
			if (res_valid)
				valid_len <= valid_len + 1;
			else
				valid_len <= 0;
		end
	end

	valid_needs_done: assert property (@(posedge clk) disable iff (reset)
		res_valid |-> done)
		else $error("res_valid high while done is low");

	single_product: assert property (@(posedge clk) disable iff (reset)
		mp_start |-> !engine_busy)
		else $error("product started while the engine was busy");

	burst_length: assert property (@(posedge clk) disable iff (reset)
		$fell(res_valid) |-> valid_len == NUM_WORDS)
		else $error("res_valid burst length differs from the word count");

endmodule

bind modexp_top modexp_assertions u_assertions (
	.clk(clk),
	.reset(reset),
	.done(done),
	.res_valid(res_valid),
	.mp_start(mp.start),
	.mp_done(mp.done)
);

//--- verification/modexp_tb.sv
//************************************************************
// inputs change on the falling edge, r, t and nprime0 come
// from a wide arithmetic model, first error stops the run
//************************************************************
`include "modexp_defines.svh"

module modexp_tb;
	import montgomery_pkg::*;

	localparam int BITS = `MODEXP_WORD_WIDTH * `MODEXP_NUM_WORDS;
	localparam int NUM_VEC = 10;
	localparam int DONE_TIMEOUT = 200000;
	localparam int VALID_TIMEOUT = 16;

	typedef logic [BITS-1:0] operand_t;
	typedef logic [2*BITS-1:0] wide_t;

	logic clk;
	logic reset;
	logic start_input;
	logic start_compute;
	logic get_result;
	word_t m_in;
	word_t e_in;
	word_t r_in;
	word_t t_in;
	word_t n_in;
	word_t nprime0_in;
	logic done;
	logic res_valid;
	word_t res_out;

	operand_t vec_m [NUM_VEC];
	operand_t vec_e [NUM_VEC];
	operand_t vec_n [NUM_VEC];
	operand_t vec_expect [NUM_VEC];
	logic [63:0] rng_state;
	int errors;

	modexp_top uut (
		.clk(clk),
		.reset(reset),
		.start_input(start_input),
		.start_compute(start_compute),
		.get_result(get_result),
		.m_in(m_in),
		.e_in(e_in),
		.r_in(r_in),
		.t_in(t_in),
		.n_in(n_in),
		.nprime0_in(nprime0_in),
		.done(done),
		.res_valid(res_valid),
		.res_out(res_out)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	function automatic logic [63:0] xorshift64(input logic [63:0] x);
		logic [63:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 7);
		y = y ^ (y << 17);
		return y;
	endfunction

	function automatic operand_t mul_mod(input operand_t a, input operand_t b, input operand_t n);
		wide_t p;
		p = wide_t'(a) * wide_t'(b);
		return operand_t'(p % wide_t'(n));
	endfunction

	function automatic operand_t pow_mod(input operand_t m, input operand_t e, input operand_t n);
		operand_t acc;
		int i;
		acc = operand_t'(wide_t'(1) % wide_t'(n));
		for (i = BITS - 1; i >= 0; i--) begin
			acc = mul_mod(acc, acc, n);
			if (e[i])
				acc = mul_mod(acc, m, n);
		end
		return acc;
	endfunction

	function automatic operand_t mont_radix(input operand_t n);	// 2^BITS mod n
		wide_t big;
		big = wide_t'(1) << BITS;
		return operand_t'(big % wide_t'(n));
	endfunction

	function automatic word_t neg_inverse(input word_t n0);
		word_t x;
		x = n0;	// already right in three bits for odd n0
		repeat (6)
			x = x * (word_t'(2) - n0 * x);
		return word_t'(0) - x;
	endfunction

	function automatic operand_t odd_modulus(input operand_t x);
		operand_t n;
		n = x;
		n[0] = 1'b1;
		n[BITS-1] = 1'b1;
		return n;
	endfunction

	task automatic draw_operand(output operand_t v);
		int k;
		for (k = 0; k < NUM_WORDS; k++) begin
			rng_state = xorshift64(rng_state);
			v[k*WORD_WIDTH +: WORD_WIDTH] = rng_state[WORD_WIDTH-1:0];
		end
	endtask

	task automatic abort_run();
		$display("*** TEST FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic check_value(input operand_t got, input operand_t expected, input string what);
		if (got !== expected) begin
			errors++;
			$display("mismatch at %0t: %s, got %h expected %h", $time, what, got, expected);
			abort_run();
		end
	endtask

	task automatic load_operands(input operand_t m, e, r, t, n, input word_t np);
		int k;
		@(negedge clk);
		start_input = 1'b1;
		for (k = 0; k < NUM_WORDS; k++) begin
			@(negedge clk);
			start_input = 1'b0;
			m_in = m[k*WORD_WIDTH +: WORD_WIDTH];
			e_in = e[k*WORD_WIDTH +: WORD_WIDTH];
		end
		for (k = 0; k < NUM_WORDS; k++) begin
			@(negedge clk);
			r_in = r[k*WORD_WIDTH +: WORD_WIDTH];
			t_in = t[k*WORD_WIDTH +: WORD_WIDTH];
			n_in = n[k*WORD_WIDTH +: WORD_WIDTH];
			nprime0_in = (k == 0) ? np : '0;
		end
		@(negedge clk);
		m_in = '0;
		e_in = '0;
		r_in = '0;
		t_in = '0;
		n_in = '0;
		nprime0_in = '0;
	endtask

	task automatic run_compute(input int v);
		int waited;
		repeat (2) @(negedge clk);	// loaded, then waiting for compute
		start_compute = 1'b1;
		@(negedge clk);
		start_compute = 1'b0;
		waited = 0;
		while (done !== 1'b1) begin
			if (waited == DONE_TIMEOUT) begin
				$display("timeout: done never came for vector %0d", v);
				abort_run();
			end
			@(negedge clk);
			waited++;
		end
	endtask

	task automatic read_result(input int v, output operand_t value);
		int waited;
		int k;
		@(negedge clk);
		get_result = 1'b1;
		@(negedge clk);
		get_result = 1'b0;
		waited = 0;
		while (res_valid !== 1'b1) begin
			if (waited == VALID_TIMEOUT) begin
				$display("timeout: res_valid never came for vector %0d", v);
				abort_run();
			end
			@(negedge clk);
			waited++;
		end
		check_value(waited, 0, "res_valid one cycle after get_result");
		for (k = 0; k < NUM_WORDS; k++) begin
			check_value(res_valid, 1, $sformatf("res_valid for word %0d", k));
			check_value(done, 1, "done while streaming");
			value[k*WORD_WIDTH +: WORD_WIDTH] = res_out;
			@(negedge clk);
		end
		check_value(res_valid, 0, "res_valid after the last word");
		check_value(done, 0, "done after the last word");
		check_value(res_out, 0, "res_out after the last word");
	endtask

	initial begin
		int v;
		operand_t r;
		operand_t t;
		operand_t got;
		word_t np;
		reset = 1'b1;
		start_input = 1'b0;
		start_compute = 1'b0;
		get_result = 1'b0;
		m_in = '0;
		e_in = '0;
		r_in = '0;
		t_in = '0;
		n_in = '0;
		nprime0_in = '0;
		errors = 0;
		rng_state = 64'd9;

		vec_n[0] = odd_modulus(operand_t'(64'hF123_4567_89AB_CDEF));
		vec_m[0] = operand_t'(64'h0123_4567_89AB_CDE0) % vec_n[0];
		vec_e[0] = operand_t'(1);
		vec_n[1] = odd_modulus(operand_t'(64'hE5A3_0C71_9B24_D6F5));
		vec_m[1] = operand_t'(64'h7777_1234_ABCD_0001) % vec_n[1];
		vec_e[1] = '0;
		vec_n[2] = odd_modulus(operand_t'(64'hB7E1_5162_8AED_2A6B));
		vec_m[2] = operand_t'(64'h5851_F42D_4C95_7F2D) % vec_n[2];
		vec_e[2] = '1;	// every bit squares and multiplies
		vec_n[3] = odd_modulus(operand_t'(64'hD1B5_4A32_D192_ED03));
		vec_m[3] = '0;
		vec_e[3] = operand_t'(32'h0001_0001);
		for (v = 4; v < NUM_VEC; v++) begin
			draw_operand(vec_n[v]);
			vec_n[v] = odd_modulus(vec_n[v]);
			draw_operand(vec_m[v]);
			vec_m[v] = vec_m[v] % vec_n[v];
			draw_operand(vec_e[v]);
		end
		for (v = 0; v < NUM_VEC; v++)
			vec_expect[v] = pow_mod(vec_m[v], vec_e[v], vec_n[v]);

		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);
		check_value(done, 0, "done after reset");
		check_value(res_valid, 0, "res_valid after reset");
		check_value(res_out, 0, "res_out after reset");

		// the same DUT runs every vector without another reset
		for (v = 0; v < NUM_VEC; v++) begin
			r = mont_radix(vec_n[v]);
			t = mul_mod(r, r, vec_n[v]);
			np = neg_inverse(vec_n[v][WORD_WIDTH-1:0]);
			load_operands(vec_m[v], vec_e[v], r, t, vec_n[v], np);
			run_compute(v);
			read_result(v, got);
			check_value(got, vec_expect[v], $sformatf("m^e mod n for vector %0d", v));
		end

		if (errors == 0) begin
			$display("*** TEST PASSED ***");
			$finish;
		end else begin
			abort_run();
		end
	end

endmodule

//--- verilog/exp_sequencer.sv
//************************************************************
// left to right square and multiply over e, e = 0 gives 1
//************************************************************
module exp_sequencer (
	input logic clk,
	input logic reset,
	input logic start_compute,
	input logic get_result,
	input logic loaded,
	store_read_if.user rd,
	monpro_if.sequencer mp,
	output logic done,
	output logic res_valid,
	output montgomery_pkg::word_t res_out
);
	import montgomery_pkg::*;
	import modexp_ctrl_pkg::*;

	localparam word_idx_t LAST_WORD = word_idx_t'(NUM_WORDS - 1);
	localparam exp_bit_t TOP_BIT = exp_bit_t'(WORD_WIDTH * NUM_WORDS - 1);

	word_t m_bar [NUM_WORDS];
	word_t c_bar [NUM_WORDS];
	exp_phase_t phase;
	exp_bit_t bit_ptr;
	word_idx_t cnt;	// copy and output word counter
	logic launched;	// a product is running
	logic seen;	// leading one of e reached
	logic e_bit;
	logic last_bit;

	assign e_bit = rd.e_word[bit_ptr % WORD_WIDTH];
	assign last_bit = (bit_ptr == '0);

	always_comb begin
		case (phase)
			to_mont: rd.rd_idx = launched ? mp.b_idx : cnt;	// t feeds b while it runs
			square, multiply: rd.rd_idx = word_idx_t'(bit_ptr / WORD_WIDTH);
			default: rd.rd_idx = '0;
		endcase
	end

	always_comb begin
		mp.a_word = '0;
		mp.b_word = '0;
		case (phase)
			to_mont: begin
				mp.a_word = m_bar[mp.a_idx];
				mp.b_word = rd.t_word;
			end
			square: begin
				mp.a_word = c_bar[mp.a_idx];
				mp.b_word = c_bar[mp.b_idx];
			end
			multiply: begin
				mp.a_word = c_bar[mp.a_idx];
				mp.b_word = m_bar[mp.b_idx];
			end
			from_mont: begin
				mp.a_word = word_t'(mp.a_idx == '0);	// the constant one
				mp.b_word = c_bar[mp.b_idx];
			end
			default: mp.a_word = '0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (phase == to_mont) begin
			c_bar[rd.rd_idx] <= rd.r_word;	// c_bar starts as R mod n
			if (!launched)
				m_bar[cnt] <= rd.m_word;
			else if (mp.res_we)
				m_bar[mp.res_idx] <= mp.res_word;
		end else if (mp.res_we) begin
			c_bar[mp.res_idx] <= mp.res_word;
		end
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			phase <= idle;
			bit_ptr <= '0;
			cnt <= '0;
			launched <= 1'b0;
			seen <= 1'b0;
			mp.start <= 1'b0;
			done <= 1'b0;
			res_valid <= 1'b0;
			res_out <= '0;
		end else begin
			mp.start <= 1'b0;
			case (phase)
				idle: if (loaded) phase <= wait_compute;
				wait_compute: begin
					if (!loaded) begin
						phase <= idle;	// a new load has begun
					end else if (start_compute) begin
						cnt <= '0;
						launched <= 1'b0;
						phase <= to_mont;
					end
				end
				to_mont: begin
					if (!launched) begin
						if (cnt == LAST_WORD) begin
							launched <= 1'b1;
							mp.start <= 1'b1;
						end else begin
							cnt <= cnt + 1'b1;
						end
					end else if (mp.done) begin
						launched <= 1'b0;
						seen <= 1'b0;
						bit_ptr <= TOP_BIT;
						phase <= square;
					end
				end
				square: begin
					if (!launched) begin
						if (seen || e_bit) begin
							launched <= 1'b1;
							seen <= 1'b1;
							mp.start <= 1'b1;
						end else if (last_bit) begin
							phase <= from_mont;	// e is zero
						end else begin
							bit_ptr <= bit_ptr - 1'b1;	// skip a leading zero
						end
					end else if (mp.done) begin
						launched <= 1'b0;
						if (e_bit)
							phase <= multiply;
						else if (last_bit)
							phase <= from_mont;
						else
							bit_ptr <= bit_ptr - 1'b1;
					end
				end
				multiply: begin
					if (!launched) begin
						launched <= 1'b1;
						mp.start <= 1'b1;
					end else if (mp.done) begin
						launched <= 1'b0;
						if (last_bit) begin
							phase <= from_mont;
						end else begin
							bit_ptr <= bit_ptr - 1'b1;
							phase <= square;
						end
					end
				end
				from_mont: begin
					if (!launched) begin
						launched <= 1'b1;
						mp.start <= 1'b1;
					end else if (mp.done) begin
						launched <= 1'b0;
						done <= 1'b1;
						phase <= result_ready;
					end
				end
				result_ready: begin
					if (get_result) begin
						res_valid <= 1'b1;
						res_out <= c_bar[0];
						cnt <= '0;
						phase <= streaming;
					end
				end
				streaming: begin
					if (cnt == LAST_WORD) begin
						res_valid <= 1'b0;
						res_out <= '0;
						done <= 1'b0;
						phase <= finished;
					end else begin
						cnt <= cnt + 1'b1;
						res_out <= c_bar[cnt + 1'b1];
					end
				end
				finished: if (!loaded) phase <= idle;
				default: phase <= idle;
			endcase
		end
	end

endmodule

//--- verilog/modexp_ctrl_pkg.sv
//************************************************************
// control encodings for the exponent scan and the CIOS steps
//************************************************************
`include "modexp_defines.svh"

package modexp_ctrl_pkg;

	typedef enum logic [3:0] {
		idle, wait_compute, to_mont, square, multiply,
		from_mont, result_ready, streaming, finished
	} exp_phase_t;

	typedef enum logic [2:0] {
		mul_row, row_carry, reduce_factor, reduce_row, reduce_carry, top_carry
	} monpro_step_t;

	// points at one bit of the whole exponent
	typedef logic [$clog2(`MODEXP_WORD_WIDTH * `MODEXP_NUM_WORDS)-1:0] exp_bit_t;

endpackage

//--- verilog/modexp_ifs.sv
//************************************************************
// internal buses, all returned words are combinational
//************************************************************
interface store_read_if;
	import montgomery_pkg::*;

	word_idx_t rd_idx;	// from the sequencer
	word_t m_word;
	word_t e_word;
	word_t r_word;
	word_t t_word;

	modport store (
		input rd_idx,
		output m_word, e_word, r_word, t_word
	);

	modport user (
		output rd_idx,
		input m_word, e_word, r_word, t_word
	);
endinterface

interface monpro_if;
	import montgomery_pkg::*;

	logic start;	// one cycle, only while the engine is idle
	word_idx_t a_idx;
	word_idx_t b_idx;
	word_t a_word;
	word_t b_word;
	logic res_we;
	word_idx_t res_idx;
	word_t res_word;
	logic done;	// one cycle after the last result word

	modport engine (
		input start, a_word, b_word,
		output a_idx, b_idx, res_we, res_idx, res_word, done
	);

	modport sequencer (
		output start, a_word, b_word,
		input a_idx, b_idx, res_we, res_idx, res_word, done
	);
endinterface

//--- verilog/modexp_top.sv
//************************************************************
// m^e mod n for odd n, software supplies r, t and nprime0
//************************************************************
module modexp_top (
	input logic clk,
	input logic reset,
	input logic start_input,
	input logic start_compute,
	input logic get_result,
	input montgomery_pkg::word_t m_in,
	input montgomery_pkg::word_t e_in,
	input montgomery_pkg::word_t r_in,
	input montgomery_pkg::word_t t_in,
	input montgomery_pkg::word_t n_in,
	input montgomery_pkg::word_t nprime0_in,
	output logic done,
	output logic res_valid,
	output montgomery_pkg::word_t res_out
);
	import montgomery_pkg::*;

	store_read_if rd();
	monpro_if mp();

	logic loaded;
	word_idx_t n_idx;
	word_t n_word;
	word_t nprime0;

	operand_store u_store (
		.clk(clk),
		.reset(reset),
		.start_input(start_input),
		.m_in(m_in),
		.e_in(e_in),
		.r_in(r_in),
		.t_in(t_in),
		.n_in(n_in),
		.nprime0_in(nprime0_in),
		.loaded(loaded),
		.rd(rd.store),
		.n_idx(n_idx),
		.n_word(n_word),
		.nprime0(nprime0)
	);

	monpro_engine u_engine (
		.clk(clk),
		.reset(reset),
		.mp(mp.engine),
		.n_idx(n_idx),
		.n_word(n_word),
		.nprime0(nprime0)
	);

	exp_sequencer u_seq (
		.clk(clk),
		.reset(reset),
		.start_compute(start_compute),
		.get_result(get_result),
		.loaded(loaded),
		.rd(rd.user),
		.mp(mp.sequencer),
		.done(done),
		.res_valid(res_valid),
		.res_out(res_out)
	);

endmodule

//--- verilog/monpro_engine.sv
//************************************************************
// CIOS product a*b/R mod n, inputs must be below n
// the result is brought below n before it is written out
//************************************************************
module monpro_engine (
	input logic clk,
	input logic reset,
	monpro_if.engine mp,
	output montgomery_pkg::word_idx_t n_idx,
	input montgomery_pkg::word_t n_word,
	input montgomery_pkg::word_t nprime0
);
	import montgomery_pkg::*;
	import modexp_ctrl_pkg::*;

	localparam word_idx_t LAST_WORD = word_idx_t'(NUM_WORDS - 1);
	localparam ext_idx_t TOP_WORD = ext_idx_t'(NUM_WORDS);
	localparam ext_idx_t OVF_WORD = ext_idx_t'(NUM_WORDS + 1);

	word_t v [NUM_WORDS+2];	// scratch vector
	word_t carry;
	word_t q;	// reduction factor of the current row
	mac_t mac;
	word_t mac_x;
	word_t mac_y;
	word_t mac_z;
	word_t mac_c;
	monpro_step_t step;
	word_idx_t i;
	word_idx_t j;
	ext_idx_t vj;
	logic running;
	logic issued;	// high on the capture cycle
	logic draining;
	logic cmp_pass;	// first drain pass only finds v >= n
	logic borrow;
	logic ge;
	word_t n_sel;
	logic [WORD_WIDTH:0] diff;

	assign vj = ext_idx_t'(j);
	assign n_idx = j;
	assign mp.a_idx = i;
	assign mp.b_idx = j;

	always_comb begin
		mac_x = '0;
		mac_y = '0;
		mac_z = '0;
		mac_c = carry;
		case (step)
			mul_row: begin
				mac_x = mp.a_word;
				mac_y = mp.b_word;
				mac_z = v[vj];
			end
			row_carry: mac_z = v[TOP_WORD];
			reduce_factor: begin
				mac_x = v[0];
				mac_y = nprime0;
				mac_c = '0;
			end
			reduce_row: begin
				mac_x = q;
				mac_y = n_word;
				mac_z = v[vj];
			end
			reduce_carry: mac_z = v[TOP_WORD];
			top_carry: mac_z = v[OVF_WORD];
			default: mac_c = '0;
		endcase
	end

	// the single multiply-add unit
	always_ff @(posedge clk) begin
		mac <= mac_x * mac_y + mac_z + mac_c;
	end

	assign n_sel = (cmp_pass || ge) ? n_word : '0;
	assign diff = v[vj] - n_sel - borrow;	// diff[WORD_WIDTH] is the borrow out
	assign mp.res_we = draining && !cmp_pass;
	assign mp.res_idx = j;
	assign mp.res_word = diff[WORD_WIDTH-1:0];

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			running <= 1'b0;
			issued <= 1'b0;
			draining <= 1'b0;
			cmp_pass <= 1'b0;
			borrow <= 1'b0;
			ge <= 1'b0;
			step <= mul_row;
			i <= '0;
			j <= '0;
			carry <= '0;
			q <= '0;
			mp.done <= 1'b0;
			for (int k = 0; k < NUM_WORDS + 2; k++)
				v[k] <= '0;
		end else begin
			mp.done <= 1'b0;
			if (running) begin
				issued <= !issued;
				if (issued) begin
					case (step)
						mul_row: begin
							v[vj] <= mac.sum;
							carry <= mac.carry;
							if (j == LAST_WORD) begin
								j <= '0;
								step <= row_carry;
							end else begin
								j <= j + 1'b1;
							end
						end
						row_carry: begin
							v[TOP_WORD] <= mac.sum;
							v[OVF_WORD] <= mac.carry;
							carry <= '0;
							step <= reduce_factor;
						end
						reduce_factor: begin
							q <= mac.sum;	// only the low word counts
							step <= reduce_row;
						end
						reduce_row: begin
							if (j != '0)
								v[vj - 1'b1] <= mac.sum;	// shift down one word
							carry <= mac.carry;
							if (j == LAST_WORD) begin
								j <= '0;
								step <= reduce_carry;
							end else begin
								j <= j + 1'b1;
							end
						end
						reduce_carry: begin
							v[TOP_WORD - 1'b1] <= mac.sum;
							carry <= mac.carry;
							step <= top_carry;
						end
						default: begin	// top_carry
							v[TOP_WORD] <= mac.sum;
							carry <= '0;
							step <= mul_row;
							if (i == LAST_WORD) begin
								running <= 1'b0;
								draining <= 1'b1;
								cmp_pass <= 1'b1;
							end else begin
								i <= i + 1'b1;
							end
						end
					endcase
				end
			end else if (draining) begin
				if (j == LAST_WORD) begin
					j <= '0;
					borrow <= 1'b0;
					if (cmp_pass) begin
						cmp_pass <= 1'b0;
						ge <= (|v[TOP_WORD]) | ~diff[WORD_WIDTH];
					end else begin
						draining <= 1'b0;
						carry <= '0;
						mp.done <= 1'b1;
						for (int k = 0; k < NUM_WORDS + 2; k++)
							v[k] <= '0;	// ready for the next product
					end
				end else begin
					j <= j + 1'b1;
					borrow <= diff[WORD_WIDTH];
				end
			end else if (mp.start) begin
				running <= 1'b1;
				issued <= 1'b0;
				step <= mul_row;
				i <= '0;
				j <= '0;
			end
		end
	end

endmodule

//--- verilog/montgomery_pkg.sv
//************************************************************
// word level types for the Montgomery datapath
//************************************************************
`include "modexp_defines.svh"

package montgomery_pkg;

	localparam int WORD_WIDTH = `MODEXP_WORD_WIDTH;
	localparam int NUM_WORDS = `MODEXP_NUM_WORDS;

	typedef logic [WORD_WIDTH-1:0] word_t;

	// x*y + z + c always fits in two words
	typedef struct packed {
		word_t carry;	// high word
		word_t sum;	// low word
	} mac_t;

	typedef logic [$clog2(NUM_WORDS)-1:0] word_idx_t;
	typedef logic [$clog2(NUM_WORDS+2)-1:0] ext_idx_t;	// scratch vector has two extra words

endpackage

//--- verilog/operand_store.sv
//************************************************************
// words arrive least significant first, m and e then r, t, n
// nprime0 is taken with the first word of r, t and n
//************************************************************
module operand_store (
	input logic clk,
	input logic reset,
	input logic start_input,
	input montgomery_pkg::word_t m_in,
	input montgomery_pkg::word_t e_in,
	input montgomery_pkg::word_t r_in,
	input montgomery_pkg::word_t t_in,
	input montgomery_pkg::word_t n_in,
	input montgomery_pkg::word_t nprime0_in,
	output logic loaded,
	store_read_if.store rd,
	input montgomery_pkg::word_idx_t n_idx,
	output montgomery_pkg::word_t n_word,
	output montgomery_pkg::word_t nprime0
);
	import montgomery_pkg::*;

	localparam word_idx_t LAST_WORD = word_idx_t'(NUM_WORDS - 1);

	word_t m_mem [NUM_WORDS];
	word_t e_mem [NUM_WORDS];
	word_t r_mem [NUM_WORDS];
	word_t t_mem [NUM_WORDS];
	word_t n_mem [NUM_WORDS];
	logic busy;
	logic second;	// high during the r, t, n pass
	word_idx_t ld_idx;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			busy <= 1'b0;
			second <= 1'b0;
			ld_idx <= '0;
			loaded <= 1'b0;
		end else if (start_input) begin
			busy <= 1'b1;
			second <= 1'b0;
			ld_idx <= '0;
			loaded <= 1'b0;	// old operands no longer valid
		end else if (busy) begin
			if (ld_idx == LAST_WORD) begin
				ld_idx <= '0;
				second <= 1'b1;
				if (second) begin
					busy <= 1'b0;
					loaded <= 1'b1;
				end
			end else begin
				ld_idx <= ld_idx + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (busy && !second) begin
			m_mem[ld_idx] <= m_in;
			e_mem[ld_idx] <= e_in;
		end
		if (busy && second) begin
			r_mem[ld_idx] <= r_in;
			t_mem[ld_idx] <= t_in;
			n_mem[ld_idx] <= n_in;
			if (ld_idx == '0)
				nprime0 <= nprime0_in;
		end
	end

	assign rd.m_word = m_mem[rd.rd_idx];
	assign rd.e_word = e_mem[rd.rd_idx];
	assign rd.r_word = r_mem[rd.rd_idx];
	assign rd.t_word = t_mem[rd.rd_idx];
	assign n_word = n_mem[n_idx];

endmodule
